/* filelist.f */
design/sq_pkg.sv
design/sq_entry.sv
design/sq_alloc_ctrl.sv
design/sq_launch_ctrl.sv
design/store_queue.sv
verification/store_queue_properties.sv
verification/store_queue_tb.sv

/* Makefile */
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the store queue testbench with Verilator"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing --assert -f filelist.f --top-module store_queue_tb -o sim_sq
	@out="$$(./obj_dir/sim_sq)"; echo "$$out"; echo "$$out" | grep -qx "NO ERRORS"

clean:
	rm -rf obj_dir

/* verification/store_queue_tb.sv */
// Directed and seeded random checks of the store queue; tags stay below 32 and are never reused while live
`default_nettype none

module store_queue_tb;

    import sq_pkg::*;

    // Expected life stage of each store, indexed by its ROB tag
    typedef enum logic [2:0] {FREE, SPEC, RETIRED, IN_FLIGHT, FILL_WAIT} model_t;

    logic                     clk;
    logic                     i_reset;
    logic                     i_alloc_en;
    sq_store_t                i_alloc;
    logic                     i_rob_retire_en;
    logic [ROB_IDX_WIDTH-1:0] i_rob_retire_tag;
    logic                     o_rob_retire_ack;
    logic                     o_launch_en;
    sq_store_t                o_launch;
    logic                     i_update_en;
    sq_update_t               i_update;
    logic                     i_mhq_fill_en;
    logic                     i_flush;
    logic                     o_full;
    logic                     o_empty;
    logic [SQ_DEPTH-1:0]      o_nonspec_mask;

    model_t    cls [32];
    sq_store_t model_store [32];
    logic      busy;
    int        busy_tag;
    int        errors;
    int        seed;

    store_queue i_store_queue (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic check_bit(input string name, input logic exp, input logic act);
        assert (act === exp) else begin
            errors++;
            $display("Error at %0t: %s expected %b got %b", $time, name, exp, act);
        end
    endtask

    // Occupancy is every tag that is not FREE, sampled mid-cycle
    // Retired, in-flight and fill-waiting stores all count as nonspeculative
    task automatic check_status();
        int cnt;
        int nonspec;
        cnt     = 0;
        nonspec = 0;
        for (int t = 0; t < 32; t++) begin
            if (cls[t] != FREE) cnt++;
            if (cls[t] inside {RETIRED, IN_FLIGHT, FILL_WAIT}) nonspec++;
        end
        check_bit("o_full", cnt == SQ_DEPTH, o_full);
        check_bit("o_empty", cnt == 0, o_empty);
        assert ($countones(o_nonspec_mask) == nonspec) else begin
            errors++;
            $display("Error at %0t: o_nonspec_mask expected %0d bits set got %b", $time,
                     nonspec, o_nonspec_mask);
        end
    endtask

    task automatic alloc_store(input int tag);
        sq_store_t st;
        int        op_sel;
        op_sel = int'($unsigned($random(seed)) % 3);
        case (op_sel)
            0: st.op = SB;
            1: st.op = SH;
            default: st.op = SW;
        endcase
        st.tag  = tag[ROB_IDX_WIDTH-1:0];
        st.addr = $random(seed);
        st.data = $random(seed);
        @(negedge clk);
        check_bit("o_full", 1'b0, o_full);
        i_alloc_en       = 1'b1;
        i_alloc          = st;
        model_store[tag] = st;
        cls[tag]         = SPEC;
        @(negedge clk);
        i_alloc_en = 1'b0;
        check_status();
    endtask

    // Ack is expected only for a store that is still speculative
    task automatic rob_retire(input int tag);
        logic exp;
        @(negedge clk);
        exp              = (cls[tag] == SPEC);
        i_rob_retire_en  = 1'b1;
        i_rob_retire_tag = tag[ROB_IDX_WIDTH-1:0];
        @(posedge clk);
        check_bit("o_rob_retire_ack", exp, o_rob_retire_ack);
        @(negedge clk);
        i_rob_retire_en = 1'b0;
        if (exp) cls[tag] = RETIRED;
    endtask

    // A negative tag accepts whichever store launches
    task automatic wait_launch(input int tag);
        int n;
        n = 0;
        while (!busy && n < 40) begin
            @(negedge clk);
            n++;
        end
        if (!busy) begin
            errors++;
            $display("Timeout while waiting for a launch of tag %0d", tag);
        end else if (tag >= 0) begin
            assert (busy_tag == tag) else begin
                errors++;
                $display("Error at %0t: o_launch.tag expected %0d got %0d", $time, tag, busy_tag);
            end
        end
    endtask

    task automatic send_update(input logic r, input logic rp, input logic mr, input logic mrp);
        @(negedge clk);
        i_update_en           = 1'b1;
        i_update.retry        = r;
        i_update.replay       = rp;
        i_update.mhq_retry    = mr;
        i_update.mhq_replay   = mrp;
        if (busy) begin
            if (rp || mrp) cls[busy_tag] = RETIRED;
            else if (r && mr) cls[busy_tag] = FILL_WAIT;
            else cls[busy_tag] = FREE;
            busy = 1'b0;
        end
        @(negedge clk);
        i_update_en = 1'b0;
        check_status();
    endtask

    task automatic mhq_fill();
        @(negedge clk);
        i_mhq_fill_en = 1'b1;
        for (int t = 0; t < 32; t++) begin
            if (cls[t] == FILL_WAIT) cls[t] = RETIRED;
        end
        @(negedge clk);
        i_mhq_fill_en = 1'b0;
    endtask

    // Speculative stores vanish and the in-flight store goes back to the launch pool
    task automatic flush_queue();
        @(negedge clk);
        i_flush = 1'b1;
        for (int t = 0; t < 32; t++) begin
            if (cls[t] == SPEC) cls[t] = FREE;
        end
        if (busy) begin
            cls[busy_tag] = RETIRED;
            busy          = 1'b0;
        end
        @(negedge clk);
        i_flush = 1'b0;
        check_status();
    endtask

    // Every launch must carry a retired store and come with nothing else in flight
    task automatic watch_launches();
        forever begin
            @(posedge clk);
            if (!i_reset && o_launch_en) begin
                assert (!busy) else begin
                    errors++;
                    $display("A second launch came at %0t before an outcome", $time);
                end
                assert (cls[o_launch.tag] == RETIRED) else begin
                    errors++;
                    $display("Tag %0d launched at %0t without waiting to launch", o_launch.tag,
                             $time);
                end
                assert (o_launch === model_store[o_launch.tag]) else begin
                    errors++;
                    $display("Error at %0t: o_launch expected %h got %h", $time,
                             model_store[o_launch.tag], o_launch);
                end
                cls[o_launch.tag] = IN_FLIGHT;
                busy              = 1'b1;
                busy_tag          = int'(o_launch.tag);
            end
        end
    endtask

    initial begin
        int rtag;
        seed             = 32'h0b244397;
        errors           = 0;
        busy             = 1'b0;
        busy_tag         = 0;
        i_reset          = 1'b1;
        i_alloc_en       = 1'b0;
        i_alloc          = '0;
        i_rob_retire_en  = 1'b0;
        i_rob_retire_tag = '0;
        i_update_en      = 1'b0;
        i_update         = '0;
        i_mhq_fill_en    = 1'b0;
        i_flush          = 1'b0;
        for (int t = 0; t < 32; t++) cls[t] = FREE;
        repeat (4) @(posedge clk);
        @(negedge clk);
        i_reset = 1'b0;
        fork
            watch_launches();
        join_none
        @(negedge clk);
        check_bit("o_launch_en", 1'b0, o_launch_en);
        check_bit("o_rob_retire_ack", 1'b0, o_rob_retire_ack);
        check_status();

        // Fill the queue, then probe with a tag that was never allocated
        for (int i = 0; i < SQ_DEPTH; i++) alloc_store(i);
        rtag = 16 + int'($unsigned($random(seed)) % 16);
        rob_retire(rtag);

        // Plain completion, and a second retire of the same tag gets no ack
        rob_retire(3);
        rob_retire(3);
        wait_launch(3);
        send_update(1'b0, 1'b0, 1'b0, 1'b0);

        // Replay, fill wait and then completion of one store
        rob_retire(5);
        wait_launch(5);
        send_update(1'b0, 1'b1, 1'b0, 1'b0);
        wait_launch(5);
        send_update(1'b1, 1'b0, 1'b1, 1'b0);
        repeat (8) @(negedge clk);
        mhq_fill();
        wait_launch(5);
        send_update(1'b0, 1'b0, 1'b0, 1'b1);
        wait_launch(5);
        send_update(1'b1, 1'b0, 1'b0, 1'b0);

        // Flush with one store in flight and the rest speculative
        rob_retire(1);
        wait_launch(1);
        flush_queue();
        rob_retire(0);
        wait_launch(1);
        send_update(1'b0, 1'b0, 1'b1, 1'b0);

        // Random stores retired together, launched in whatever order the queue picks
        for (int i = 0; i < 4; i++) alloc_store(8 + i);
        for (int i = 0; i < 4; i++) rob_retire(8 + i);
        for (int i = 0; i < 4; i++) begin
            wait_launch(-1);
            send_update(1'b0, 1'b0, 1'b0, 1'b0);
        end

        // A flush with only speculative stores leaves the queue empty
        alloc_store(12);
        alloc_store(13);
        flush_queue();
        rob_retire(13);
        repeat (4) @(negedge clk);
        check_status();

        $display("Run finished with %0d errors", errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verification/store_queue_properties.sv */
// Bound into the launch controller and every entry; unused inputs of each binding are tied off
`default_nettype none

module store_queue_properties (
    input logic                        clk,
    input logic                        i_reset,
    input logic                        i_flush,
    input logic                        i_update_en,
    input logic                        i_launch_en,
    input logic [sq_pkg::SQ_DEPTH-1:0] i_retire_vec,
    input logic [sq_pkg::SQ_DEPTH-1:0] i_update_vec,
    input logic                        i_ack,
    input logic [2:0]                  i_state
);

    import sq_pkg::*;

    logic                pending_r;
    logic [SQ_DEPTH-1:0] last_retire_r;

    // A launched store stays outstanding until its outcome or a flush arrives
    always_ff @(posedge clk) begin
        if (i_reset) begin
            pending_r <= 1'b0;
        end else begin
            pending_r <= (pending_r | i_launch_en) & ~(i_update_en | i_flush);
        end
    end

    // Remember which entry the last launch picked
    always_ff @(posedge clk) begin
        if (|i_retire_vec) begin
            last_retire_r <= i_retire_vec;
        end
    end

    // Nothing new may launch while the pipeline holds a store
    a_no_launch_in_flight: assert property (@(posedge clk) disable iff (i_reset)
        i_launch_en |-> !pending_r) else $error("launch while a store is in flight");

    // An outcome goes to the entry that was launched last and to no other
    a_update_onehot: assert property (@(posedge clk) disable iff (i_reset)
        $onehot0(i_update_vec) && (i_update_vec == '0 || i_update_vec == last_retire_r))
        else $error("update vector does not select the launched entry");

    // Only the five encodings of the entry FSM are legal
    a_state_legal: assert property (@(posedge clk) disable iff (i_reset)
        i_state inside {3'b000, 3'b001, 3'b100, 3'b101, 3'b110})
        else $error("entry state holds an illegal encoding");

    a_quiet_after_reset: assert property (@(posedge clk)
        $fell(i_reset) |-> (!i_launch_en && !i_ack))
        else $error("ack or launch high right after reset");

endmodule

bind sq_launch_ctrl store_queue_properties u_launch_props (
    .clk(clk), .i_reset(i_reset), .i_flush(i_flush), .i_update_en(i_update_en),
    .i_launch_en(o_launch_en), .i_retire_vec(o_retire_vec), .i_update_vec(o_update_vec),
    .i_ack(1'b0), .i_state(3'b001)
);

bind sq_entry store_queue_properties u_entry_props (
    .clk(clk), .i_reset(i_reset), .i_flush(1'b0), .i_update_en(1'b0), .i_launch_en(1'b0),
    .i_retire_vec('0), .i_update_vec('0), .i_ack(o_rob_retire_ack), .i_state(state_r)
);

`default_nettype wire

/* design/store_queue.sv */
// Store queue top; producers must hold i_alloc_en low while o_full is high
`default_nettype none

module store_queue (
    input  logic                             clk,
    input  logic                             i_reset,

    // Allocation from decode
    input  logic                             i_alloc_en,
    input  sq_pkg::sq_store_t                i_alloc,

    // ROB retire broadcast and its acknowledge
    input  logic                             i_rob_retire_en,
    input  logic [sq_pkg::ROB_IDX_WIDTH-1:0] i_rob_retire_tag,
    output logic                             o_rob_retire_ack,

    // Launch into the LSU pipeline
    output logic                             o_launch_en,
    output sq_pkg::sq_store_t                o_launch,

    // Outcome of the last launch from the LSU and MHQ
    input  logic                             i_update_en,
    input  sq_pkg::sq_update_t               i_update,

    // MHQ fill broadcast and pipeline flush
    input  logic                             i_mhq_fill_en,
    input  logic                             i_flush,

    // Status
    output logic                             o_full,
    output logic                             o_empty,
    output logic [sq_pkg::SQ_DEPTH-1:0]      o_nonspec_mask
);

    import sq_pkg::*;

    logic [SQ_DEPTH-1:0] alloc_vec;
    logic [SQ_DEPTH-1:0] empty_mask;
    logic [SQ_DEPTH-1:0] retirable_mask;
    logic [SQ_DEPTH-1:0] retire_vec;
    logic [SQ_DEPTH-1:0] update_vec;
    logic [SQ_DEPTH-1:0] ack_vec;
    sq_store_t           stores [SQ_DEPTH];

    // Every entry sees the same payload and broadcasts
    // Only its own bits of the alloc, retire and update vectors select it
    for (genvar g = 0; g < SQ_DEPTH; g++) begin : g_entry
        sq_entry u_entry (
            .clk              (clk),
            .i_reset          (i_reset),
            .i_flush          (i_flush),
            .i_alloc_en       (alloc_vec[g]),
            .i_alloc          (i_alloc),
            .i_retire_en      (retire_vec[g]),
            .i_update_en      (update_vec[g]),
            .i_update         (i_update),
            .i_mhq_fill_en    (i_mhq_fill_en),
            .i_rob_retire_en  (i_rob_retire_en),
            .i_rob_retire_tag (i_rob_retire_tag),
            .o_empty          (empty_mask[g]),
            .o_retirable      (retirable_mask[g]),
            .o_nonspeculative (o_nonspec_mask[g]),
            .o_store          (stores[g]),
            .o_rob_retire_ack (ack_vec[g])
        );
    end

    sq_alloc_ctrl u_alloc_ctrl (
        .i_alloc_en   (i_alloc_en),
        .i_empty_mask (empty_mask),
        .o_alloc_vec  (alloc_vec),
        .o_full       (o_full)
    );

    sq_launch_ctrl u_launch_ctrl (
        .clk              (clk),
        .i_reset          (i_reset),
        .i_flush          (i_flush),
        .i_retirable_mask (retirable_mask),
        .i_stores         (stores),
        .i_update_en      (i_update_en),
        .o_retire_vec     (retire_vec),
        .o_update_vec     (update_vec),
        .o_launch_en      (o_launch_en),
        .o_launch         (o_launch)
    );

    // At most one entry matches a tag, so the OR is the ack of that entry
    assign o_rob_retire_ack = |ack_vec;

    // Empty only when every slot is free
    assign o_empty = &empty_mask;

endmodule

`default_nettype wire

/* design/sq_launch_ctrl.sv */
// Only one store is in flight at a time; outcomes that arrive while nothing is in flight are ignored
`default_nettype none

module sq_launch_ctrl (
    input  logic                        clk,
    input  logic                        i_reset,
    input  logic                        i_flush,

    // Entry status and payloads
    input  logic [sq_pkg::SQ_DEPTH-1:0] i_retirable_mask,
    input  sq_pkg::sq_store_t           i_stores [sq_pkg::SQ_DEPTH],

    // Outcome strobe from the LSU and MHQ
    input  logic                        i_update_en,

    output logic [sq_pkg::SQ_DEPTH-1:0] o_retire_vec,
    output logic [sq_pkg::SQ_DEPTH-1:0] o_update_vec,
    output logic                        o_launch_en,
    output sq_pkg::sq_store_t           o_launch
);

    import sq_pkg::*;

    logic                    in_flight_r;
    logic [SQ_IDX_WIDTH-1:0] launch_idx_r;
    logic [SQ_IDX_WIDTH-1:0] sel_idx;
    logic                    launch_sel;
    logic                    update_accept;

    // Lowest retirable index wins, so scan from the top and let lower hits overwrite
    always_comb begin
        sel_idx = '0;
        for (int i = SQ_DEPTH - 1; i >= 0; i--) begin
            if (i_retirable_mask[i]) begin
                sel_idx = SQ_IDX_WIDTH'(i);
            end
        end
    end

    // A new launch is picked only when the pipeline holds none of our stores
    // This also keeps an update cycle from selecting, since in-flight is still set then
    assign launch_sel = ~in_flight_r & (|i_retirable_mask);

    // The chosen entry moves to LAUNCHED on the same edge that registers its store
    assign o_retire_vec = launch_sel ? (SQ_DEPTH'(1) << sel_idx) : '0;

    // The outcome belongs to whichever entry was launched last
    assign update_accept = i_update_en & in_flight_r;
    assign o_update_vec  = update_accept ? (SQ_DEPTH'(1) << launch_idx_r) : '0;

    always_ff @(posedge clk) begin
        if (i_reset) begin
            in_flight_r <= 1'b0;
            o_launch_en <= 1'b0;
        end else begin
            o_launch_en <= launch_sel;

            // A launch takes priority over a flush in the same cycle
            if (launch_sel) begin
                in_flight_r <= 1'b1;
            end else if (update_accept || i_flush) begin
                in_flight_r <= 1'b0;
            end
        end
    end

    // Index and payload of the launched store are only meaningful with the flags above
    always_ff @(posedge clk) begin
        if (launch_sel) begin
            launch_idx_r <= sel_idx;
            o_launch     <= i_stores[sel_idx];
        end
    end

endmodule

`default_nettype wire

/* design/sq_alloc_ctrl.sv */
// Allocation picks the lowest free slot; a request while o_full is high is dropped
`default_nettype none

module sq_alloc_ctrl (
    input  logic                        i_alloc_en,
    input  logic [sq_pkg::SQ_DEPTH-1:0] i_empty_mask,
    output logic [sq_pkg::SQ_DEPTH-1:0] o_alloc_vec,
    output logic                        o_full
);

    import sq_pkg::*;

    // Walk up from entry 0 and claim the first empty slot
    // The request strobe is folded in so the vector is all zero when idle
    always_comb begin
        logic found;

        found       = 1'b0;
        o_alloc_vec = '0;

        for (int i = 0; i < SQ_DEPTH; i++) begin
            if (i_empty_mask[i] && !found) begin
                o_alloc_vec[i] = i_alloc_en;
                found          = 1'b1;
            end
        end
    end

    // Full means no slot is empty
    // This follows the entry states directly, so it changes in the cycle after an allocation
    assign o_full = ~|i_empty_mask;

endmodule

`default_nettype wire

/* design/sq_entry.sv */
// One store slot; the caller must only allocate it while empty and only launch it while retirable
`default_nettype none

module sq_entry (
    input  logic                             clk,
    input  logic                             i_reset,
    input  logic                             i_flush,

    // Allocation from decode
    input  logic                             i_alloc_en,
    input  sq_pkg::sq_store_t                i_alloc,

    // Launch strobe and outcome from the launch controller
    input  logic                             i_retire_en,
    input  logic                             i_update_en,
    input  sq_pkg::sq_update_t               i_update,

    // Fill broadcast from the MHQ
    input  logic                             i_mhq_fill_en,

    // Retire broadcast from the ROB
    input  logic                             i_rob_retire_en,
    input  logic [sq_pkg::ROB_IDX_WIDTH-1:0] i_rob_retire_tag,

    output logic                             o_empty,
    output logic                             o_retirable,
    output logic                             o_nonspeculative,
    output sq_pkg::sq_store_t                o_store,
    output logic                             o_rob_retire_ack
);

    import sq_pkg::*;

    sq_state_t state_r;
    sq_state_t state_next;
    sq_store_t store_r;
    logic      rob_match;

    // The ROB only retires a store that is still speculative
    // At most one VALID entry can hold a given tag
    assign rob_match = i_rob_retire_en & (state_r == VALID) & (store_r.tag == i_rob_retire_tag);

    always_comb begin
        sq_state_t fill_state;
        sq_state_t update_state;

        // A fill in the same cycle as a retry wakes the store at once
        fill_state = i_mhq_fill_en ? NONSPECULATIVE : MHQ_FILL_WAIT;

        // Replays go straight back to the launch pool
        // Only retry together with mhq_retry waits for a fill, anything else completes the store
        if (i_update.replay || i_update.mhq_replay) begin
            update_state = NONSPECULATIVE;
        end else if (i_update.retry && i_update.mhq_retry) begin
            update_state = fill_state;
        end else begin
            update_state = INVALID;
        end

        state_next = state_r;

        unique case (state_r)
            INVALID: begin
                if (i_alloc_en) state_next = VALID;
            end
            VALID: begin
                // Flush wins over a retire in the same cycle
                if (i_flush) state_next = INVALID;
                else if (rob_match) state_next = NONSPECULATIVE;
            end
            MHQ_FILL_WAIT: begin
                if (i_mhq_fill_en) state_next = NONSPECULATIVE;
            end
            NONSPECULATIVE: begin
                if (i_retire_en) state_next = LAUNCHED;
            end
            LAUNCHED: begin
                // A flush kills the pipeline copy, so the store must go again
                if (i_flush) state_next = NONSPECULATIVE;
                else if (i_update_en) state_next = update_state;
            end
            default: state_next = INVALID;
        endcase
    end

    always_ff @(posedge clk) begin
        if (i_reset) begin
            state_r <= INVALID;
        end else begin
            state_r <= state_next;
        end
    end

    // Payload is captured once at allocation and held until the slot is reused
    always_ff @(posedge clk) begin
        if (i_alloc_en) begin
            store_r <= i_alloc;
        end
    end

    assign o_empty          = (state_r == INVALID);
    assign o_retirable      = (state_r == NONSPECULATIVE);
    // MHQ_FILL_WAIT, NONSPECULATIVE and LAUNCHED all share the top bit
    assign o_nonspeculative = state_r[STATE_WIDTH-1];
    assign o_store          = store_r;
    assign o_rob_retire_ack = rob_match;

endmodule

`default_nettype wire

/* design/sq_pkg.sv */
// Sizes are fixed here for the whole queue; state encodings follow the LSU's existing store queue
`default_nettype none

package sq_pkg;

    // Number of store queue entries and the width of an index into them
    localparam int SQ_DEPTH     = 8;
    localparam int SQ_IDX_WIDTH = 3;

    // Store payload widths
    localparam int ADDR_WIDTH    = 32;
    localparam int DATA_WIDTH    = 32;
    localparam int ROB_IDX_WIDTH = 5;

    // Encoding widths for the opcode and the entry state
    localparam int OP_WIDTH    = 2;
    localparam int STATE_WIDTH = 3;

    // Store opcodes for byte, half-word and word stores
    typedef enum logic [OP_WIDTH-1:0] {
        SB = 2'b00,
        SH = 2'b01,
        SW = 2'b10
    } sq_op_t;

    // Entry states
    // The top bit is set for every state that holds a retired store
    // INVALID holds nothing, VALID holds a store the ROB has not retired yet
    // MHQ_FILL_WAIT parks a retired store until the miss handling queue fills its line
    // NONSPECULATIVE is ready to launch, LAUNCHED is waiting for the LSU outcome
    typedef enum logic [STATE_WIDTH-1:0] {
        INVALID        = 3'b000,
        VALID          = 3'b001,
        MHQ_FILL_WAIT  = 3'b100,
        NONSPECULATIVE = 3'b101,
        LAUNCHED       = 3'b110
    } sq_state_t;

    // One store as it is allocated, held and launched
    // The tag is the ROB index of the store
    typedef struct packed {
        sq_op_t                   op;
        logic [ROB_IDX_WIDTH-1:0] tag;
        logic [ADDR_WIDTH-1:0]    addr;
        logic [DATA_WIDTH-1:0]    data;
    } sq_store_t;

    // Outcome of a launch as reported by the LSU and the MHQ
    // These bits only mean something while the separate update enable is high
    typedef struct packed {
        logic retry;
        logic replay;
        logic mhq_retry;
        logic mhq_replay;
    } sq_update_t;

endpackage

`default_nettype wire
